// ==== bp_defs.svh ====
// Size and register map macros for the branch predictor, included by the package and RTL
`ifndef BP_DEFS_SVH
`define BP_DEFS_SVH

// PC and target width
`define BP_XLEN 32

// Target buffer depth, power of two
`define BP_BTB_ENTRIES 32

// Global history length, pattern table holds 2**BP_GHR_BITS counters
`define BP_GHR_BITS 5

// Register block address width and offsets
`define BP_CSR_ADDR_BITS 2
`define BP_CSR_CTRL 2'd0
`define BP_CSR_MISPRED 2'd1

// CTRL bit positions
`define BP_CTRL_EN_BIT 0
`define BP_CTRL_CLR_BIT 1

`endif

// ==== bp_pkg.sv ====
// Shared types for the branch predictor, referenced by scoped name from the RTL
`include "bp_defs.svh"

package bp_pkg;

    localparam int BTB_IDX_BITS = $clog2(`BP_BTB_ENTRIES);
    localparam int BTB_TAG_BITS = `BP_XLEN - BTB_IDX_BITS - 2; // PC bits above index and byte offset

    // RV32 major opcodes seen by the predictor
    typedef enum logic [6:0] {
        OP_OTHER  = 7'b0000000,
        OP_BRANCH = 7'b1100011,
        OP_JALR   = 7'b1100111,
        OP_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [1:0] {
        BK_NONE = 2'd0,
        BK_COND = 2'd1,
        BK_JUMP = 2'd2
    } br_kind_e;

    typedef logic [1:0] ctr_t; // High bit is the direction
    localparam ctr_t CTR_WEAK_NT = 2'b01;

    typedef struct packed {
        logic                    valid;
        br_kind_e                kind;
        logic [BTB_TAG_BITS-1:0] tag;
        logic [`BP_XLEN-1:0]     target;
    } btb_entry_t;

    localparam btb_entry_t BTB_ENTRY_EMPTY = '{valid: 1'b0, kind: BK_NONE, tag: '0, target: '0};

endpackage

// ==== bp_table.sv ====
// Register array with one write port and two unclocked read ports, entry type set per instance
`timescale 1ns/1ps

module bp_table #(
    parameter type    entry_t   = logic [1:0],
    parameter int     DEPTH     = 32,
    parameter entry_t RESET_VAL = '0
) (
    input  logic                     clk,
    input  logic                     arst_n_i,
    input  logic                     we_i,
    input  logic [$clog2(DEPTH)-1:0] waddr_i,
    input  entry_t                   wdata_i,
    input  logic [$clog2(DEPTH)-1:0] raddr_a_i,
    output entry_t                   rdata_a_o,
    input  logic [$clog2(DEPTH)-1:0] raddr_b_i,
    output entry_t                   rdata_b_o
);

    entry_t mem [DEPTH];

    // Every entry starts from a known state so lookups after reset are defined
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= RESET_VAL;
            end
        end else if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    assign rdata_a_o = mem[raddr_a_i]; // Lookup port
    assign rdata_b_o = mem[raddr_b_i]; // Update side port

    // A write strobe must always carry a resolved address
    a_waddr_known: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        we_i |-> !$isunknown(waddr_i)
    ) else $error("bp_table write with unknown address");

endmodule

// ==== bp_btb.sv ====
// Tagged direct-mapped branch target buffer with same-cycle write forwarding
`timescale 1ns/1ps
`include "bp_defs.svh"

module bp_btb (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic [`BP_XLEN-1:0]  lookup_pc_i,
    output logic                 hit_o,
    output bp_pkg::br_kind_e     kind_o,
    output logic [`BP_XLEN-1:0]  target_o,
    input  logic                 upd_valid_i,
    input  logic [`BP_XLEN-1:0]  upd_pc_i,
    input  logic [6:0]           upd_op_i,
    input  logic                 upd_taken_i,
    input  logic [`BP_XLEN-1:0]  upd_target_i
);

    localparam int IDX_BITS = bp_pkg::BTB_IDX_BITS;

    logic [IDX_BITS-1:0]           lk_idx;
    logic [bp_pkg::BTB_TAG_BITS-1:0] lk_tag;
    logic [IDX_BITS-1:0]           wr_idx;
    bp_pkg::br_kind_e              upd_kind;
    logic                          install;
    bp_pkg::btb_entry_t            wr_entry;
    bp_pkg::btb_entry_t            rd_entry;
    bp_pkg::btb_entry_t            lk_entry;

    assign lk_idx = lookup_pc_i[IDX_BITS+1:2];
    assign lk_tag = lookup_pc_i[`BP_XLEN-1:IDX_BITS+2];
    assign wr_idx = upd_pc_i[IDX_BITS+1:2];

    always_comb begin
        case (upd_op_i)
            bp_pkg::OP_BRANCH: upd_kind = bp_pkg::BK_COND;
            bp_pkg::OP_JAL,
            bp_pkg::OP_JALR:   upd_kind = bp_pkg::BK_JUMP;
            default:           upd_kind = bp_pkg::BK_NONE;
        endcase
    end

    // Jumps always install, conditional branches only when taken
    assign install = upd_valid_i && (upd_kind != bp_pkg::BK_NONE)
                     && (upd_taken_i || upd_kind == bp_pkg::BK_JUMP);

    assign wr_entry = '{valid:  1'b1,
                        kind:   upd_kind,
                        tag:    upd_pc_i[`BP_XLEN-1:IDX_BITS+2],
                        target: upd_target_i};

    bp_table #(
        .entry_t   (bp_pkg::btb_entry_t),
        .DEPTH     (`BP_BTB_ENTRIES),
        .RESET_VAL (bp_pkg::BTB_ENTRY_EMPTY)
    ) u_btb_tbl (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .we_i      (install),
        .waddr_i   (wr_idx),
        .wdata_i   (wr_entry),
        .raddr_a_i (lk_idx),
        .rdata_a_o (rd_entry),
        .raddr_b_i (wr_idx),
        .rdata_b_o ()
    );

    // Forward an install to the same index within the cycle
    assign lk_entry = (install && wr_idx == lk_idx) ? wr_entry : rd_entry;

    assign hit_o    = lk_entry.valid && (lk_entry.tag == lk_tag);
    assign kind_o   = lk_entry.kind;
    assign target_o = lk_entry.target;

    // Only branch kinds are ever installed, so a hit never carries none
    a_hit_has_kind: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        hit_o |-> kind_o != bp_pkg::BK_NONE
    ) else $error("BTB hit with kind none");

endmodule

// ==== bp_gshare.sv ====
// Gshare direction predictor: global history, PC hash and 2-bit counter training
`timescale 1ns/1ps
`include "bp_defs.svh"

module bp_gshare (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  logic [`BP_XLEN-1:0]     lookup_pc_i,
    output logic [`BP_GHR_BITS-1:0] idx_o,
    output logic                    pred_taken_o,
    input  logic                    upd_valid_i,
    input  logic [6:0]              upd_op_i,
    input  logic                    upd_taken_i,
    input  logic [`BP_GHR_BITS-1:0] upd_idx_i,
    input  logic                    hist_clr_i
);

    localparam int HBITS = `BP_GHR_BITS;
    localparam int DEPTH = 1 << HBITS;

    logic [HBITS-1:0] ghr;
    logic             is_cond;
    bp_pkg::ctr_t     ctr_lk;
    bp_pkg::ctr_t     ctr_old;
    bp_pkg::ctr_t     ctr_new;

    assign is_cond = upd_valid_i && (upd_op_i == bp_pkg::OP_BRANCH);

    // Hash of PC word bits and history
    assign idx_o = lookup_pc_i[HBITS+1:2] ^ ghr;

    bp_table #(
        .entry_t   (bp_pkg::ctr_t),
        .DEPTH     (DEPTH),
        .RESET_VAL (bp_pkg::CTR_WEAK_NT)
    ) u_pht (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .we_i      (is_cond),
        .waddr_i   (upd_idx_i),
        .wdata_i   (ctr_new),
        .raddr_a_i (idx_o),
        .rdata_a_o (ctr_lk),
        .raddr_b_i (upd_idx_i),
        .rdata_b_o (ctr_old)
    );

    assign pred_taken_o = ctr_lk[1];

    // Saturating step, held at 0 and 3
    always_comb begin
        ctr_new = ctr_old;
        if (upd_taken_i) begin
            if (ctr_old != 2'b11) begin
                ctr_new = ctr_old + 2'b01;
            end
        end else if (ctr_old != 2'b00) begin
            ctr_new = ctr_old - 2'b01;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ghr <= '0;
        end else if (hist_clr_i) begin
            ghr <= '0; // Clear has priority over a shift
        end else if (is_cond) begin
            ghr <= {ghr[HBITS-2:0], upd_taken_i}; // Newest outcome in bit 0
        end
    end

    // A strongly taken counter trained taken again is still strongly taken
    a_ctr_sat_hi: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        (is_cond && upd_taken_i && ctr_old == 2'b11)
            |=> u_pht.mem[$past(upd_idx_i)] == 2'b11
    ) else $error("PHT counter wrapped past 3");

endmodule

// ==== bp_csr.sv ====
// Predictor configuration and status registers: enable, history clear, mispredict count
`timescale 1ns/1ps
`include "bp_defs.svh"

module bp_csr (
    input  logic                         clk,
    input  logic                         arst_n_i,
    input  logic                         csr_we_i,
    input  logic [`BP_CSR_ADDR_BITS-1:0] csr_addr_i,
    input  logic [`BP_XLEN-1:0]          csr_wdata_i,
    output logic [`BP_XLEN-1:0]          csr_rdata_o,
    input  logic                         upd_valid_i,
    input  logic                         upd_mispredict_i,
    output logic                         pred_en_o,
    output logic                         hist_clr_o
);

    logic        wr_ctrl;
    logic        wr_mispred;
    logic        pred_en;
    logic [31:0] mispred_cnt;

    assign wr_ctrl    = csr_we_i && (csr_addr_i == `BP_CSR_CTRL);
    assign wr_mispred = csr_we_i && (csr_addr_i == `BP_CSR_MISPRED);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pred_en <= 1'b1; // Predict from reset on
        end else if (wr_ctrl) begin
            pred_en <= csr_wdata_i[`BP_CTRL_EN_BIT];
        end
    end

    // Write-one pulse, history clears on the same edge as the write
    assign hist_clr_o = wr_ctrl && csr_wdata_i[`BP_CTRL_CLR_BIT];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mispred_cnt <= '0;
        end else if (wr_mispred) begin
            mispred_cnt <= '0; // Any write clears
        end else if (upd_valid_i && upd_mispredict_i && mispred_cnt != '1) begin
            mispred_cnt <= mispred_cnt + 32'd1;
        end
    end

    always_comb begin
        case (csr_addr_i)
            `BP_CSR_CTRL: begin
                csr_rdata_o = '0;
                csr_rdata_o[`BP_CTRL_EN_BIT] = pred_en; // Clear bit reads as zero
            end
            `BP_CSR_MISPRED: csr_rdata_o = mispred_cnt;
            default:         csr_rdata_o = '0;
        endcase
    end

    assign pred_en_o = pred_en;

endmodule

// ==== bp_top.sv ====
// Branch prediction unit top: BTB, gshare direction and register block
`timescale 1ns/1ps
`include "bp_defs.svh"

module bp_top (
    input  logic                         clk,
    input  logic                         arst_n_i,
    input  logic [`BP_XLEN-1:0]          lookup_pc_i,
    output logic                         pred_taken_o,
    output logic [`BP_XLEN-1:0]          pred_target_o,
    output logic [`BP_GHR_BITS-1:0]      pred_idx_o,
    input  logic                         upd_valid_i,
    input  logic [`BP_XLEN-1:0]          upd_pc_i,
    input  logic [6:0]                   upd_op_i,
    input  logic                         upd_taken_i,
    input  logic [`BP_XLEN-1:0]          upd_target_i,
    input  logic [`BP_GHR_BITS-1:0]      upd_idx_i,
    input  logic                         upd_mispredict_i,
    input  logic                         csr_we_i,
    input  logic [`BP_CSR_ADDR_BITS-1:0] csr_addr_i,
    input  logic [`BP_XLEN-1:0]          csr_wdata_i,
    output logic [`BP_XLEN-1:0]          csr_rdata_o
);

    logic                btb_hit;
    bp_pkg::br_kind_e    btb_kind;
    logic [`BP_XLEN-1:0] btb_target;
    logic                dir_taken;
    logic                pred_en;
    logic                hist_clr;

    bp_btb u_btb (
        .clk(clk), .arst_n_i(arst_n_i),
        .lookup_pc_i(lookup_pc_i),
        .hit_o(btb_hit), .kind_o(btb_kind), .target_o(btb_target),
        .upd_valid_i(upd_valid_i), .upd_pc_i(upd_pc_i), .upd_op_i(upd_op_i),
        .upd_taken_i(upd_taken_i), .upd_target_i(upd_target_i)
    );

    bp_gshare u_gshare (
        .clk(clk), .arst_n_i(arst_n_i),
        .lookup_pc_i(lookup_pc_i), .idx_o(pred_idx_o), .pred_taken_o(dir_taken),
        .upd_valid_i(upd_valid_i), .upd_op_i(upd_op_i), .upd_taken_i(upd_taken_i),
        .upd_idx_i(upd_idx_i), .hist_clr_i(hist_clr)
    );

    bp_csr u_csr (
        .clk(clk), .arst_n_i(arst_n_i),
        .csr_we_i(csr_we_i), .csr_addr_i(csr_addr_i),
        .csr_wdata_i(csr_wdata_i), .csr_rdata_o(csr_rdata_o),
        .upd_valid_i(upd_valid_i), .upd_mispredict_i(upd_mispredict_i),
        .pred_en_o(pred_en), .hist_clr_o(hist_clr)
    );

    // Jumps go on a hit, conditionals need the counter as well
    assign pred_taken_o  = pred_en && btb_hit
                           && (btb_kind == bp_pkg::BK_JUMP
                               || (btb_kind == bp_pkg::BK_COND && dir_taken));
    assign pred_target_o = pred_taken_o ? btb_target : '0;

endmodule

// ==== tb_clk_gen.sv ====
// Clock and reset source for the branch predictor testbench, instantiated by its top module
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS  = 8,
    parameter int RST_CYCLES = 3
) (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end

    // Reset releases just after the last reset edge
    initial begin
        arst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        #1 arst_n_o = 1'b1;
    end

endmodule

// ==== tb_bp_top.sv ====
// Top-level testbench for bp_top, run as the simulation top, with a reference model and per-cycle checks
`timescale 1ns/1ps
`include "bp_defs.svh"

module tb_bp_top;

    localparam int XLEN     = `BP_XLEN;
    localparam int HB       = `BP_GHR_BITS;
    localparam int BI       = $clog2(`BP_BTB_ENTRIES);
    localparam int CYCLE_NS = 8;
    localparam int RUN_CYCLES = 3 + 21 + 9 + 41 + 6 + 8 + 35; // Reset plus each test
    localparam logic [XLEN-1:0] PC_A = 32'h0000_2014;
    localparam logic [XLEN-1:0] PC_B = 32'h0000_2094; // Same BTB index as PC_A
    localparam logic [XLEN-1:0] PC_C = 32'h0000_3000;

    logic                         clk;
    logic                         arst_n;
    logic [XLEN-1:0]              lookup_pc;
    logic                         pred_taken;
    logic [XLEN-1:0]              pred_target;
    logic [HB-1:0]                pred_idx;
    logic                         upd_valid;
    logic [XLEN-1:0]              upd_pc;
    logic [6:0]                   upd_op;
    logic                         upd_taken;
    logic [XLEN-1:0]              upd_target;
    logic [HB-1:0]                upd_idx;
    logic                         upd_mispredict;
    logic                         csr_we;
    logic [`BP_CSR_ADDR_BITS-1:0] csr_addr;
    logic [XLEN-1:0]              csr_wdata;
    logic [XLEN-1:0]              csr_rdata;

    // Model state
    logic [HB-1:0]      m_hist;
    logic [1:0]         m_ctr [2**HB];
    logic               m_valid [2**BI];
    logic               m_jump [2**BI];
    logic [XLEN-BI-3:0] m_tag [2**BI];
    logic [XLEN-1:0]    m_tgt [2**BI];
    logic               m_en;
    logic [31:0]        m_cnt;

    logic               m_is_cond;
    logic               m_is_jump;
    logic               m_install;
    logic               m_clr;
    logic [BI-1:0]      l_idx;
    logic               l_jump;
    logic [XLEN-1:0]    l_tgt;
    logic               e_hit;
    logic               e_taken;
    logic [XLEN-1:0]    e_target;
    logic [HB-1:0]      e_idx;
    logic [XLEN-1:0]    e_rdata;

    int err_cnt    = 0;
    int pass_cnt   = 0;
    int fail_cnt   = 0;
    int taken_seen = 0;
    int test_errs;
    int test_taken;

    tb_clk_gen #(.PERIOD_NS(CYCLE_NS), .RST_CYCLES(3)) u_clk_gen (.clk_o(clk), .arst_n_o(arst_n));

    bp_top i_dut (
        .clk(clk), .arst_n_i(arst_n), .lookup_pc_i(lookup_pc),
        .pred_taken_o(pred_taken), .pred_target_o(pred_target), .pred_idx_o(pred_idx),
        .upd_valid_i(upd_valid), .upd_pc_i(upd_pc), .upd_op_i(upd_op),
        .upd_taken_i(upd_taken), .upd_target_i(upd_target), .upd_idx_i(upd_idx),
        .upd_mispredict_i(upd_mispredict), .csr_we_i(csr_we), .csr_addr_i(csr_addr),
        .csr_wdata_i(csr_wdata), .csr_rdata_o(csr_rdata)
    );

    always_comb begin
        m_is_cond = upd_valid && upd_op == bp_pkg::OP_BRANCH;
        m_is_jump = upd_valid && (upd_op == bp_pkg::OP_JAL || upd_op == bp_pkg::OP_JALR);
        m_install = m_is_jump || (m_is_cond && upd_taken);
        m_clr     = csr_we && csr_addr == `BP_CSR_CTRL && csr_wdata[1];
        l_idx     = lookup_pc[BI+1:2];
        if (m_install && upd_pc[BI+1:2] == l_idx) begin // Write seen in the same cycle
            e_hit  = upd_pc[XLEN-1:BI+2] == lookup_pc[XLEN-1:BI+2];
            l_jump = m_is_jump;
            l_tgt  = upd_target;
        end else begin
            e_hit  = m_valid[l_idx] && m_tag[l_idx] == lookup_pc[XLEN-1:BI+2];
            l_jump = m_jump[l_idx];
            l_tgt  = m_tgt[l_idx];
        end
        e_idx    = lookup_pc[HB+1:2] ^ m_hist;
        e_taken  = m_en && e_hit && (l_jump || m_ctr[e_idx][1]);
        e_target = e_taken ? l_tgt : '0;
        if (csr_addr == `BP_CSR_CTRL) e_rdata = {{(XLEN-1){1'b0}}, m_en};
        else if (csr_addr == `BP_CSR_MISPRED) e_rdata = m_cnt;
        else e_rdata = '0;
    end

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            m_hist <= '0;
            m_en   <= 1'b1;
            m_cnt  <= '0;
            for (int i = 0; i < 2**HB; i++) begin
                m_ctr[i] <= 2'b01;
            end
            for (int i = 0; i < 2**BI; i++) begin
                m_valid[i] <= 1'b0;
                m_jump[i]  <= 1'b0;
                m_tag[i]   <= '0;
                m_tgt[i]   <= '0;
            end
        end else begin
            if (m_install) begin
                m_valid[upd_pc[BI+1:2]] <= 1'b1;
                m_jump[upd_pc[BI+1:2]]  <= m_is_jump;
                m_tag[upd_pc[BI+1:2]]   <= upd_pc[XLEN-1:BI+2];
                m_tgt[upd_pc[BI+1:2]]   <= upd_target;
            end
            if (m_is_cond && upd_taken && m_ctr[upd_idx] != 2'd3) begin
                m_ctr[upd_idx] <= m_ctr[upd_idx] + 2'd1;
            end else if (m_is_cond && !upd_taken && m_ctr[upd_idx] != 2'd0) begin
                m_ctr[upd_idx] <= m_ctr[upd_idx] - 2'd1;
            end
            if (m_clr) m_hist <= '0;
            else if (m_is_cond) m_hist <= {m_hist[HB-2:0], upd_taken};
            if (csr_we && csr_addr == `BP_CSR_CTRL) m_en <= csr_wdata[0];
            if (csr_we && csr_addr == `BP_CSR_MISPRED) m_cnt <= '0;
            else if (upd_valid && upd_mispredict && m_cnt != '1) m_cnt <= m_cnt + 32'd1;
            if (e_taken) taken_seen <= taken_seen + 1;
        end
    end

    function automatic void log_mismatch(string name, logic [XLEN-1:0] exp, logic [XLEN-1:0] got);
        err_cnt++;
        $display("error at %0t: %s expected %0h, DUT %0h", $time, name, exp, got);
    endfunction

    a_taken: assert property (@(posedge clk) disable iff (!arst_n) pred_taken === e_taken)
        else log_mismatch("pred_taken_o", $sampled(e_taken), $sampled(pred_taken));
    a_target: assert property (@(posedge clk) disable iff (!arst_n) pred_target === e_target)
        else log_mismatch("pred_target_o", $sampled(e_target), $sampled(pred_target));
    a_idx: assert property (@(posedge clk) disable iff (!arst_n) pred_idx === e_idx)
        else log_mismatch("pred_idx_o", $sampled(e_idx), $sampled(pred_idx));
    a_rdata: assert property (@(posedge clk) disable iff (!arst_n) csr_rdata === e_rdata)
        else log_mismatch("csr_rdata_o", $sampled(e_rdata), $sampled(csr_rdata));

    function automatic logic [XLEN-1:0] rand_pc();
        return $urandom() & ~32'h3;
    endfunction

    // Strobes last one cycle unless driven again
    task automatic next_cycle();
        @(posedge clk);
        #1;
        upd_valid      = 1'b0;
        upd_mispredict = 1'b0;
        csr_we         = 1'b0;
    endtask

    task automatic lookup_only(input logic [XLEN-1:0] pc);
        next_cycle();
        lookup_pc = pc;
    endtask

    // upd_idx is the hash fetch would have carried for this PC
    task automatic send_update(input logic [XLEN-1:0] pc, input logic [6:0] op, input logic taken,
                               input logic [XLEN-1:0] tgt, input logic mis,
                               input logic [XLEN-1:0] lk_pc);
        next_cycle();
        lookup_pc      = lk_pc;
        upd_valid      = 1'b1;
        upd_pc         = pc;
        upd_op         = op;
        upd_taken      = taken;
        upd_target     = tgt;
        upd_idx        = pc[HB+1:2] ^ m_hist;
        upd_mispredict = mis;
    endtask

    task automatic csr_write(input logic [`BP_CSR_ADDR_BITS-1:0] addr,
                             input logic [XLEN-1:0] data);
        next_cycle();
        csr_we    = 1'b1;
        csr_addr  = addr;
        csr_wdata = data;
    endtask

    task automatic start_test();
        test_errs  = err_cnt;
        test_taken = taken_seen;
    endtask

    task automatic finish_test(input string name, input logic need_taken);
        next_cycle(); // Last driven cycle gets checked at this edge
        if (need_taken && taken_seen == test_taken) begin
            err_cnt++;
            $display("test %s never reached a taken prediction", name);
        end
        if (err_cnt == test_errs) begin
            pass_cnt++;
            $display("test %s: passed", name);
        end else begin
            fail_cnt++;
            $display("test %s: failed", name);
        end
    endtask

    task automatic reset_lookups();
        start_test();
        for (int i = 0; i < 20; i++) begin
            lookup_only(rand_pc());
        end
        finish_test("reset lookups", 1'b0);
    endtask

    task automatic jump_install();
        logic [XLEN-1:0] pc;
        start_test();
        for (int i = 0; i < 4; i++) begin
            pc = rand_pc();
            send_update(pc, i[0] ? bp_pkg::OP_JALR : bp_pkg::OP_JAL, 1'b1, rand_pc(), 1'b0, pc);
            lookup_only(pc);
        end
        finish_test("jump install", 1'b1);
    endtask

    // Ten taken then ten not-taken drive both ends of the counters into saturation
    task automatic cond_training();
        start_test();
        for (int i = 0; i < 20; i++) begin
            send_update(PC_C, bp_pkg::OP_BRANCH, i < 10, PC_C + 32'h100, 1'b0, PC_C);
            lookup_only(PC_C);
        end
        finish_test("conditional training", 1'b1);
    endtask

    task automatic btb_alias();
        start_test();
        send_update(PC_A, bp_pkg::OP_JAL, 1'b1, 32'h0000_4000, 1'b0, PC_A);
        lookup_only(PC_B);
        send_update(PC_B, bp_pkg::OP_JALR, 1'b1, 32'h0000_5000, 1'b0, PC_B);
        lookup_only(PC_A);
        lookup_only(PC_B);
        finish_test("btb alias", 1'b1);
    endtask

    task automatic enable_and_clear();
        start_test();
        send_update(PC_C, bp_pkg::OP_BRANCH, 1'b1, 32'h0000_6000, 1'b0, PC_C);
        csr_write(`BP_CSR_CTRL, 32'h0);
        lookup_only(PC_B); // Would hit as a jump
        csr_write(`BP_CSR_CTRL, 32'h3);
        lookup_only(PC_B);
        send_update(PC_C, bp_pkg::OP_BRANCH, 1'b1, 32'h0000_6000, 1'b0, PC_C);
        csr_we    = 1'b1; // Clear lands on the same edge as the branch update
        csr_addr  = `BP_CSR_CTRL;
        csr_wdata = 32'h3;
        lookup_only(PC_C);
        finish_test("enable and history clear", 1'b1);
    endtask

    task automatic mispredict_count();
        logic [6:0]      ops [4];
        logic [XLEN-1:0] pc;
        int              tally;
        start_test();
        ops   = '{bp_pkg::OP_BRANCH, bp_pkg::OP_JAL, bp_pkg::OP_JALR, bp_pkg::OP_OTHER};
        tally = 0;
        csr_write(`BP_CSR_MISPRED, '0);
        for (int i = 0; i < 30; i++) begin
            pc = rand_pc();
            send_update(pc, ops[$urandom_range(3)], $urandom_range(1), rand_pc(),
                        $urandom_range(1), rand_pc());
            if ($urandom_range(3) == 0) upd_valid = 1'b0; // Flag without strobe
            else if (upd_mispredict) tally++;
        end
        lookup_only(rand_pc());
        if (csr_rdata !== 32'(tally)) log_mismatch("csr_rdata_o", 32'(tally), csr_rdata);
        csr_write(`BP_CSR_MISPRED, '0);
        lookup_only(rand_pc());
        finish_test("mispredict count", 1'b0);
    endtask

    initial begin : watchdog
        #((RUN_CYCLES + 100) * CYCLE_NS);
        $display("timeout: run did not finish within %0d cycles", RUN_CYCLES + 100);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'h44aa));
        lookup_pc      = '0;
        upd_valid      = 1'b0;
        upd_pc         = '0;
        upd_op         = bp_pkg::OP_OTHER;
        upd_taken      = 1'b0;
        upd_target     = '0;
        upd_idx        = '0;
        upd_mispredict = 1'b0;
        csr_we         = 1'b0;
        csr_addr       = `BP_CSR_CTRL;
        csr_wdata      = '0;
        @(posedge arst_n);
        reset_lookups();
        jump_install();
        cond_training();
        btb_alias();
        enable_and_clear();
        mispredict_count();
        $display("tests passed %0d, failed %0d, errors %0d", pass_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+.
bp_pkg.sv
bp_table.sv
bp_btb.sv
bp_gshare.sv
bp_csr.sv
bp_top.sv
tb_clk_gen.sv
tb_bp_top.sv

// ==== Bender.yml ====
package:
  name: bp_unit

export_include_dirs:
  - .

sources:
  - bp_pkg.sv
  - bp_table.sv
  - bp_btb.sv
  - bp_gshare.sv
  - bp_csr.sv
  - bp_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_bp_top.sv
